// ==== design/chan_ahb_slave.sv ====
// AHB slave front end of one DMA channel register block.
// hready is not modeled: every transfer completes in a single data phase.
// Strobes are registered, so they line up with the data phase of the transfer.
// The source, destination and control writes are dropped while the channel is enabled.
`timescale 1ns/1ps

module chan_ahb_slave #(
  parameter logic [dma_chan_pkg::ADDR_BITS-1:0] BASE_ADDR = '0
) (
  input  logic                              hclk,
  input  logic                              hrst_n,
  input  logic                              s_hsel,
  input  logic [1:0]                        s_htrans,
  input  logic [31:0]                       s_haddr,
  input  logic                              s_hwrite,
  input  logic                              chn_en,
  input  logic [31:0]                       cfg_rdata,
  input  logic [31:0]                       int_rdata,
  output logic [dma_chan_pkg::NUM_REGS-1:0] we_strb,
  output logic [dma_chan_pkg::NUM_REGS-1:0] re_strb,
  output logic [31:0]                       s_hrdata
);
  import dma_chan_pkg::*;

  logic [ADDR_BITS-1:0] addr_lo;
  logic                 xfer;
  logic [NUM_REGS-1:0]  hit;
  logic [NUM_REGS-1:0]  lock;
  logic [NUM_REGS-1:0]  we_nxt;
  logic [NUM_REGS-1:0]  re_nxt;

  assign addr_lo = s_haddr[ADDR_BITS-1:0];
  assign xfer    = s_hsel && (s_htrans == HTRANS_NONSEQ || s_htrans == HTRANS_SEQ);

  always_comb begin
    hit                 = '0;
    hit[REG_SARN]       = (addr_lo == BASE_ADDR + SARN_OFS);
    hit[REG_DARN]       = (addr_lo == BASE_ADDR + DARN_OFS);
    hit[REG_CTRL_A]     = (addr_lo == BASE_ADDR + CTRL_A_OFS);
    hit[REG_CTRL_B]     = (addr_lo == BASE_ADDR + CTRL_B_OFS);
    hit[REG_INT_MASK]   = (addr_lo == BASE_ADDR + INT_MASK_OFS);
    hit[REG_INT_STATUS] = (addr_lo == BASE_ADDR + INT_STATUS_OFS);
    hit[REG_INT_CLEAR]  = (addr_lo == BASE_ADDR + INT_CLEAR_OFS);
    hit[REG_SOFT_REQ]   = (addr_lo == BASE_ADDR + SOFT_REQ_OFS);
    hit[REG_CHN_EN]     = (addr_lo == BASE_ADDR + CHN_EN_OFS);
  end

  // channel setup is frozen while the engine may be using it.
  always_comb begin
    lock             = '0;
    lock[REG_SARN]   = chn_en;
    lock[REG_DARN]   = chn_en;
    lock[REG_CTRL_A] = chn_en;
    lock[REG_CTRL_B] = chn_en;
  end

  assign we_nxt = hit & {NUM_REGS{xfer & s_hwrite}} & ~lock;
  assign re_nxt = hit & {NUM_REGS{xfer & ~s_hwrite}};

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      we_strb <= '0;
      re_strb <= '0;
    end else begin
      we_strb <= we_nxt;
      re_strb <= re_nxt;
    end
  end

  assign s_hrdata = cfg_rdata | int_rdata; // both words are zero unless selected.

  // offsets are distinct, so one transfer can never select two registers.
  a_strb_onehot: assert property (@(posedge hclk) disable iff (!hrst_n)
    $onehot0(re_strb) && $onehot0(we_strb));

endmodule

// ==== design/chan_config_regs.sv ====
// Address and control registers of one DMA channel.
// Writes arrive as one-cycle strobes from the slave, with s_hwdata valid in that cycle.
// Group length is 4 bits; there is no length extension register.
// The transfer engine clears chn_en through chnen_clr; a software enable write wins.
`timescale 1ns/1ps

module chan_config_regs (
  input  logic                                 hclk,
  input  logic                                 hrst_n,
  input  logic [dma_chan_pkg::NUM_REGS-1:0]    we_strb,
  input  logic [dma_chan_pkg::NUM_REGS-1:0]    re_strb,
  input  logic [31:0]                          s_hwdata,
  input  logic                                 chnen_clr,
  output logic [31:0]                          sarn,
  output logic [31:0]                          darn,
  output logic                                 dgrpaddrc,
  output logic                                 sgrpaddrc,
  output logic                                 grpmc,
  output logic [2:0]                           chintmdc,
  output logic [dma_chan_pkg::BLOCK_TL_W-1:0]  block_tl,
  output logic [dma_chan_pkg::GROUP_LEN_W-1:0] group_len,
  output logic [1:0]                           sinc,
  output logic [1:0]                           dinc,
  output logic [1:0]                           src_tr_width,
  output logic [1:0]                           dst_tr_width,
  output logic [dma_chan_pkg::PROTCTL_W-1:0]   protctl,
  output logic                                 endlan,
  output logic                                 srcdtlgc,
  output logic [1:0]                           trgtmdc,
  output logic                                 prot_out,
  output logic                                 int_en,
  output logic                                 chn_en,
  output logic                                 soft_trig,
  output logic [31:0]                          cfg_rdata
);
  import dma_chan_pkg::*;

  logic [31:0] ctrl_a_word;
  logic [31:0] ctrl_b_word;

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sarn <= '0;
      darn <= '0;
    end else begin
      if (we_strb[REG_SARN]) sarn <= s_hwdata;
      if (we_strb[REG_DARN]) darn <= s_hwdata;
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      dgrpaddrc    <= 1'b0;
      sgrpaddrc    <= 1'b0;
      grpmc        <= 1'b0;
      chintmdc     <= '0;
      block_tl     <= '0;
      group_len    <= '0;
      sinc         <= '0;
      dinc         <= '0;
      src_tr_width <= '0;
      dst_tr_width <= '0;
    end else if (we_strb[REG_CTRL_A]) begin
      dgrpaddrc    <= s_hwdata[DGRPADDRC_BIT];
      sgrpaddrc    <= s_hwdata[SGRPADDRC_BIT];
      grpmc        <= s_hwdata[GRPMC_BIT];
      chintmdc     <= s_hwdata[CHINTMDC_LSB +: 3];
      block_tl     <= s_hwdata[BLOCK_TL_LSB +: BLOCK_TL_W];
      group_len    <= s_hwdata[GROUP_LEN_LSB +: GROUP_LEN_W];
      sinc         <= s_hwdata[SINC_LSB +: 2];
      dinc         <= s_hwdata[DINC_LSB +: 2];
      src_tr_width <= s_hwdata[SRC_TR_WIDTH_LSB +: 2];
      dst_tr_width <= s_hwdata[DST_TR_WIDTH_LSB +: 2];
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      protctl  <= '0;
      endlan   <= 1'b0;
      srcdtlgc <= 1'b0;
      trgtmdc  <= '0;
      int_en   <= 1'b0;
    end else if (we_strb[REG_CTRL_B]) begin
      protctl  <= s_hwdata[PROTCTL_LSB +: PROTCTL_W];
      endlan   <= s_hwdata[ENDLAN_BIT];
      srcdtlgc <= s_hwdata[SRCDTLGC_BIT];
      trgtmdc  <= s_hwdata[TRGTMDC_LSB +: 2];
      int_en   <= s_hwdata[INT_EN_BIT];
    end
  end

  assign prot_out = protctl[PROT_OUT_BIT];

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en    <= 1'b0;
      soft_trig <= 1'b0;
    end else begin
      if (we_strb[REG_CHN_EN]) chn_en <= s_hwdata[0];
      else if (chnen_clr)      chn_en <= 1'b0;
      soft_trig <= we_strb[REG_SOFT_REQ] & s_hwdata[0]; // one cycle per write.
    end
  end

  // reserved bits stay zero in the read-back words.
  always_comb begin
    ctrl_a_word                                     = '0;
    ctrl_a_word[DGRPADDRC_BIT]                      = dgrpaddrc;
    ctrl_a_word[SGRPADDRC_BIT]                      = sgrpaddrc;
    ctrl_a_word[GRPMC_BIT]                          = grpmc;
    ctrl_a_word[CHINTMDC_LSB +: 3]                  = chintmdc;
    ctrl_a_word[BLOCK_TL_LSB +: BLOCK_TL_W]         = block_tl;
    ctrl_a_word[GROUP_LEN_LSB +: GROUP_LEN_W]       = group_len;
    ctrl_a_word[SINC_LSB +: 2]                      = sinc;
    ctrl_a_word[DINC_LSB +: 2]                      = dinc;
    ctrl_a_word[SRC_TR_WIDTH_LSB +: 2]              = src_tr_width;
    ctrl_a_word[DST_TR_WIDTH_LSB +: 2]              = dst_tr_width;
  end

  always_comb begin
    ctrl_b_word                               = '0;
    ctrl_b_word[PROTCTL_LSB +: PROTCTL_W]     = protctl;
    ctrl_b_word[ENDLAN_BIT]                   = endlan;
    ctrl_b_word[SRCDTLGC_BIT]                 = srcdtlgc;
    ctrl_b_word[TRGTMDC_LSB +: 2]             = trgtmdc;
    ctrl_b_word[INT_EN_BIT]                   = int_en;
  end

  always_comb begin
    cfg_rdata = '0;
    if (re_strb[REG_SARN])   cfg_rdata = sarn;
    if (re_strb[REG_DARN])   cfg_rdata = darn;
    if (re_strb[REG_CTRL_A]) cfg_rdata = ctrl_a_word;
    if (re_strb[REG_CTRL_B]) cfg_rdata = ctrl_b_word;
    if (re_strb[REG_CHN_EN]) cfg_rdata = {31'h0, chn_en};
  end

  // relies on the slave giving a single strobe per write transfer.
  a_soft_trig_pulse: assert property (@(posedge hclk) disable iff (!hrst_n)
    soft_trig |=> !soft_trig);

endmodule

// ==== design/chan_int_ctrl.sv ====
// Interrupt mask, sticky status and clear logic of one DMA channel.
// Event inputs are sampled every clock; a set on the same edge as a clear wins.
// Clear pulses are registered, so a clear takes effect one cycle after the data phase.
// Status read-back shows bits 3:0 only; the pending bit is seen on pend.
`timescale 1ns/1ps

module chan_int_ctrl (
  input  logic                              hclk,
  input  logic                              hrst_n,
  input  logic [dma_chan_pkg::NUM_REGS-1:0] we_strb,
  input  logic [dma_chan_pkg::NUM_REGS-1:0] re_strb,
  input  logic [31:0]                       s_hwdata,
  input  logic                              int_en,
  input  logic                              err_vld,
  input  logic                              tfr_vld,
  input  logic                              htfr_vld,
  input  logic                              trgetcmp_vld,
  input  logic                              pend_vld,
  output logic                              int_req,
  output logic                              pend,
  output logic [31:0]                       int_rdata
);
  import dma_chan_pkg::*;

  logic [NUM_INT-1:0] mask;
  logic [NUM_INT-1:0] status;
  logic [NUM_INT-1:0] clr;
  logic [NUM_INT-1:0] evt;

  always_comb begin
    evt               = '0;
    evt[INT_ERR]      = err_vld;
    evt[INT_TFR]      = tfr_vld;
    evt[INT_HTFR]     = htfr_vld;
    evt[INT_TRGETCMP] = trgetcmp_vld;
    evt[INT_PEND]     = pend_vld;
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      mask   <= '0;
      clr    <= '0;
      status <= '0;
    end else begin
      if (we_strb[REG_INT_MASK]) mask <= s_hwdata[NUM_INT-1:0];
      clr    <= we_strb[REG_INT_CLEAR] ? s_hwdata[NUM_INT-1:0] : '0;
      status <= evt | (status & ~clr);
    end
  end

  assign int_req = (|(status & mask)) & int_en;
  assign pend    = status[INT_PEND];

  always_comb begin
    int_rdata = '0;
    if (re_strb[REG_INT_MASK])
      int_rdata[NUM_INT-1:0] = mask;
    if (re_strb[REG_INT_STATUS])
      int_rdata[INT_TRGETCMP:INT_ERR] = status[INT_TRGETCMP:INT_ERR];
  end

  // a clear write strobe lasts one cycle, so its pulse must too.
  a_clr_pulse: assert property (@(posedge hclk) disable iff (!hrst_n)
    |clr |=> ~|clr);

endmodule

// ==== design/dma_chan_pkg.sv ====
// Shared constants of the DMA channel register block.
// Only the low ADDR_BITS of the AHB address are decoded; the upper bits are ignored.
// Mask, status and clear registers share the INT_* bit layout.
package dma_chan_pkg;

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam int ADDR_BITS = 10;

  // offsets relative to the channel base.
  localparam logic [ADDR_BITS-1:0] SARN_OFS       = 10'h000;
  localparam logic [ADDR_BITS-1:0] DARN_OFS       = 10'h004;
  localparam logic [ADDR_BITS-1:0] CTRL_A_OFS     = 10'h008;
  localparam logic [ADDR_BITS-1:0] CTRL_B_OFS     = 10'h00c;
  localparam logic [ADDR_BITS-1:0] INT_MASK_OFS   = 10'h010;
  localparam logic [ADDR_BITS-1:0] INT_STATUS_OFS = 10'h014;
  localparam logic [ADDR_BITS-1:0] INT_CLEAR_OFS  = 10'h018;
  localparam logic [ADDR_BITS-1:0] SOFT_REQ_OFS   = 10'h01c;
  localparam logic [ADDR_BITS-1:0] CHN_EN_OFS     = 10'h020;

  // bit positions in the strobe vectors.
  localparam int REG_SARN       = 0;
  localparam int REG_DARN       = 1;
  localparam int REG_CTRL_A     = 2;
  localparam int REG_CTRL_B     = 3;
  localparam int REG_INT_MASK   = 4;
  localparam int REG_INT_STATUS = 5;
  localparam int REG_INT_CLEAR  = 6;
  localparam int REG_SOFT_REQ   = 7;
  localparam int REG_CHN_EN     = 8;
  localparam int NUM_REGS       = 9;

  localparam int BLOCK_TL_W  = 12;
  localparam int GROUP_LEN_W = 4;
  localparam int PROTCTL_W   = 4;

  // control A fields.
  localparam int DGRPADDRC_BIT    = 31;
  localparam int SGRPADDRC_BIT    = 29;
  localparam int GRPMC_BIT        = 28;
  localparam int CHINTMDC_LSB     = 24;
  localparam int BLOCK_TL_LSB     = 12;
  localparam int GROUP_LEN_LSB    = 8;
  localparam int SINC_LSB         = 6;
  localparam int DINC_LSB         = 4;
  localparam int SRC_TR_WIDTH_LSB = 2;
  localparam int DST_TR_WIDTH_LSB = 0;

  // control B fields.
  localparam int PROTCTL_LSB  = 15;
  localparam int ENDLAN_BIT   = 14;
  localparam int SRCDTLGC_BIT = 13;
  localparam int TRGTMDC_LSB  = 1;
  localparam int INT_EN_BIT   = 0;
  localparam int PROT_OUT_BIT = 2; // bit of protctl driven on prot_out.

  localparam int INT_ERR      = 0;
  localparam int INT_TFR      = 1;
  localparam int INT_HTFR     = 2;
  localparam int INT_TRGETCMP = 3;
  localparam int INT_PEND     = 4;
  localparam int NUM_INT      = 5;

endpackage

// ==== design/dma_chan_regs.sv ====
// Register block of one DMA channel behind an AHB slave port.
// BASE_ADDR is compared against the low ADDR_BITS of s_haddr only.
// No wait states are inserted; reads return data in the first data phase.
`timescale 1ns/1ps

module dma_chan_regs #(
  parameter logic [dma_chan_pkg::ADDR_BITS-1:0] BASE_ADDR = '0
) (
  input  logic                                 hclk,
  input  logic                                 hrst_n,
  input  logic                                 s_hsel,
  input  logic [1:0]                           s_htrans,
  input  logic [31:0]                          s_haddr,
  input  logic                                 s_hwrite,
  input  logic [31:0]                          s_hwdata,
  output logic [31:0]                          s_hrdata,
  input  logic                                 err_vld,
  input  logic                                 tfr_vld,
  input  logic                                 htfr_vld,
  input  logic                                 trgetcmp_vld,
  input  logic                                 pend_vld,
  input  logic                                 chnen_clr,
  output logic [31:0]                          sarn,
  output logic [31:0]                          darn,
  output logic                                 dgrpaddrc,
  output logic                                 sgrpaddrc,
  output logic                                 grpmc,
  output logic [2:0]                           chintmdc,
  output logic [dma_chan_pkg::BLOCK_TL_W-1:0]  block_tl,
  output logic [dma_chan_pkg::GROUP_LEN_W-1:0] group_len,
  output logic [1:0]                           sinc,
  output logic [1:0]                           dinc,
  output logic [1:0]                           src_tr_width,
  output logic [1:0]                           dst_tr_width,
  output logic [dma_chan_pkg::PROTCTL_W-1:0]   protctl,
  output logic                                 endlan,
  output logic                                 srcdtlgc,
  output logic [1:0]                           trgtmdc,
  output logic                                 prot_out,
  output logic                                 int_en,
  output logic                                 chn_en,
  output logic                                 soft_trig,
  output logic                                 int_req,
  output logic                                 pend
);
  import dma_chan_pkg::*;

  logic [NUM_REGS-1:0] we_strb;
  logic [NUM_REGS-1:0] re_strb;
  logic [31:0]         cfg_rdata;
  logic [31:0]         int_rdata;

  chan_ahb_slave #(
    .BASE_ADDR (BASE_ADDR)
  ) u_ahb_slave (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .s_hsel    (s_hsel),
    .s_htrans  (s_htrans),
    .s_haddr   (s_haddr),
    .s_hwrite  (s_hwrite),
    .chn_en    (chn_en),
    .cfg_rdata (cfg_rdata),
    .int_rdata (int_rdata),
    .we_strb   (we_strb),
    .re_strb   (re_strb),
    .s_hrdata  (s_hrdata)
  );

  chan_config_regs u_config_regs (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .we_strb      (we_strb),
    .re_strb      (re_strb),
    .s_hwdata     (s_hwdata),
    .chnen_clr    (chnen_clr),
    .sarn         (sarn),
    .darn         (darn),
    .dgrpaddrc    (dgrpaddrc),
    .sgrpaddrc    (sgrpaddrc),
    .grpmc        (grpmc),
    .chintmdc     (chintmdc),
    .block_tl     (block_tl),
    .group_len    (group_len),
    .sinc         (sinc),
    .dinc         (dinc),
    .src_tr_width (src_tr_width),
    .dst_tr_width (dst_tr_width),
    .protctl      (protctl),
    .endlan       (endlan),
    .srcdtlgc     (srcdtlgc),
    .trgtmdc      (trgtmdc),
    .prot_out     (prot_out),
    .int_en       (int_en),
    .chn_en       (chn_en),
    .soft_trig    (soft_trig),
    .cfg_rdata    (cfg_rdata)
  );

  chan_int_ctrl u_int_ctrl (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .we_strb      (we_strb),
    .re_strb      (re_strb),
    .s_hwdata     (s_hwdata),
    .int_en       (int_en),
    .err_vld      (err_vld),
    .tfr_vld      (tfr_vld),
    .htfr_vld     (htfr_vld),
    .trgetcmp_vld (trgetcmp_vld),
    .pend_vld     (pend_vld),
    .int_req      (int_req),
    .pend         (pend),
    .int_rdata    (int_rdata)
  );

endmodule

// ==== sources.f ====
+incdir+test
design/dma_chan_pkg.sv
design/chan_ahb_slave.sv
design/chan_config_regs.sv
design/chan_int_ctrl.sv
design/dma_chan_regs.sv
test/tb_dma_chan_regs.sv

// ==== test/tb_dma_chan_tests.svh ====
// Directed tests of the DMA channel register block.
// Included inside the testbench module; uses its bus and compare tasks.
// Each test leaves the channel disabled for the next one.

task automatic check_ctrl_a_fields(input logic [31:0] w);
  check_bit("dgrpaddrc", dgrpaddrc, w[31]);
  check_bit("sgrpaddrc", sgrpaddrc, w[29]);
  check_bit("grpmc", grpmc, w[28]);
  check_word("chintmdc", chintmdc, w[26:24]);
  check_word("block_tl", block_tl, w[23:12]);
  check_word("group_len", group_len, w[11:8]);
  check_word("sinc", sinc, w[7:6]);
  check_word("dinc", dinc, w[5:4]);
  check_word("src_tr_width", src_tr_width, w[3:2]);
  check_word("dst_tr_width", dst_tr_width, w[1:0]);
endtask

task automatic check_ctrl_b_fields(input logic [31:0] w);
  check_word("protctl", protctl, w[18:15]);
  check_bit("endlan", endlan, w[14]);
  check_bit("srcdtlgc", srcdtlgc, w[13]);
  check_word("trgtmdc", trgtmdc, w[2:1]);
  check_bit("int_en", int_en, w[0]);
  check_bit("prot_out", prot_out, w[17]); // protctl bit 2.
endtask

task automatic config_readback();
  logic [31:0] w;
  check_word("sarn", sarn, 32'h0);
  check_bit("chn_en", chn_en, 1'b0);
  check_bit("soft_trig", soft_trig, 1'b0);
  check_bit("int_req", int_req, 1'b0);
  check_bit("pend", pend, 1'b0);
  for (int i = 0; i < 3; i++) begin
    w = next_rand();
    bus_write(SARN_OFS, w);
    check_word("sarn", sarn, w);
    read_check(SARN_OFS, w, "sarn read");
    w = next_rand();
    bus_write(DARN_OFS, w);
    check_word("darn", darn, w);
    read_check(DARN_OFS, w, "darn read");
    w = next_rand();
    bus_write(CTRL_A_OFS, w);
    check_ctrl_a_fields(w);
    read_check(CTRL_A_OFS, w & CTRL_A_MASK, "ctrl_a read");
    w = next_rand();
    bus_write(CTRL_B_OFS, w);
    check_ctrl_b_fields(w);
    read_check(CTRL_B_OFS, w & CTRL_B_MASK, "ctrl_b read");
  end
endtask

task automatic write_lock();
  logic [31:0] sarn_val;
  logic [31:0] ctrl_val;
  logic [31:0] w;
  sarn_val = next_rand();
  ctrl_val = next_rand();
  bus_write(SARN_OFS, sarn_val);
  bus_write(CTRL_A_OFS, ctrl_val);
  bus_write(CHN_EN_OFS, 32'h1);
  check_bit("chn_en", chn_en, 1'b1);
  read_check(CHN_EN_OFS, 32'h1, "chn_en read");
  bus_write(SARN_OFS, ~sarn_val);
  check_word("sarn", sarn, sarn_val);
  read_check(SARN_OFS, sarn_val, "sarn read");
  bus_write(CTRL_A_OFS, ~ctrl_val);
  check_ctrl_a_fields(ctrl_val);
  read_check(CTRL_A_OFS, ctrl_val & CTRL_A_MASK, "ctrl_a read");
  bus_write(INT_MASK_OFS, 32'h0a); // mask is not locked.
  read_check(INT_MASK_OFS, 32'h0a, "int_mask read");
  @(negedge hclk);
  chnen_clr = 1'b1;
  @(negedge hclk);
  chnen_clr = 1'b0;
  check_bit("chn_en", chn_en, 1'b0);
  w = next_rand();
  bus_write(SARN_OFS, w);
  check_word("sarn", sarn, w);
  read_check(SARN_OFS, w, "sarn read");
endtask

task automatic interrupt_flow();
  bus_write(CTRL_B_OFS, 32'h1);
  check_bit("int_en", int_en, 1'b1);
  bus_write(INT_MASK_OFS, 32'h1f);
  read_check(INT_MASK_OFS, 32'h1f, "int_mask read");
  for (int i = 0; i < 5; i++) begin
    pulse_event(i);
    check_bit("int_req", int_req, 1'b1);
    check_bit("pend", pend, i == 4);
    read_check(INT_STATUS_OFS, (i < 4) ? (32'h1 << i) : 32'h0, "int_status read");
    bus_write(INT_CLEAR_OFS, 32'h1 << i);
    @(negedge hclk);
    check_bit("int_req", int_req, 1'b0);
    check_bit("pend", pend, 1'b0);
    read_check(INT_STATUS_OFS, 32'h0, "int_status read");
  end
  bus_write(CTRL_B_OFS, 32'h0);
  pulse_event(0);
  repeat (3) begin
    check_bit("int_req", int_req, 1'b0);
    @(negedge hclk);
  end
  read_check(INT_STATUS_OFS, 32'h1, "int_status read");
  bus_write(INT_CLEAR_OFS, 32'h1f);
endtask

// writes SOFT_REQ and watches soft_trig in every cycle of the access.
task automatic soft_req_write(input logic [31:0] data, input logic exp_trig);
  @(negedge hclk);
  drive_addr(1'b1, HTRANS_NONSEQ, 1'b1, SOFT_REQ_OFS);
  @(negedge hclk);
  drive_idle();
  s_hwdata = data;
  check_bit("soft_trig", soft_trig, 1'b0);
  @(negedge hclk);
  check_bit("soft_trig", soft_trig, exp_trig); // two cycles after the address phase.
  @(negedge hclk);
  check_bit("soft_trig", soft_trig, 1'b0);
endtask

task automatic soft_trigger();
  soft_req_write(32'h1, 1'b1);
  soft_req_write(32'hffff_fffe, 1'b0);
  repeat (3) begin
    check_bit("soft_trig", soft_trig, 1'b0);
    @(negedge hclk);
  end
endtask

task automatic decode_filter();
  logic [31:0] k;
  logic [31:0] d;
  logic [31:0] rd;
  k = next_rand();
  d = next_rand();
  bus_write(SARN_OFS, k);
  bus_access(1'b0, HTRANS_NONSEQ, 1'b1, SARN_OFS, ~k, rd);
  bus_access(1'b1, HTRANS_IDLE, 1'b1, SARN_OFS, ~k, rd);
  bus_access(1'b1, HTRANS_BUSY, 1'b1, SARN_OFS, ~k, rd);
  check_word("sarn", sarn, k);
  read_check(SARN_OFS, k, "sarn read");
  bus_access(1'b0, HTRANS_NONSEQ, 1'b0, SARN_OFS, 32'h0, rd);
  check_word("deselected read", rd, 32'h0);
  read_check(32'h24, 32'h0, "unmapped read");
  read_check(32'h3fc, 32'h0, "unmapped read");
  bus_access(1'b1, HTRANS_SEQ, 1'b1, DARN_OFS, d, rd);
  check_word("darn", darn, d);
  bus_access(1'b1, HTRANS_SEQ, 1'b0, DARN_OFS, 32'h0, rd);
  check_word("darn seq read", rd, d);
endtask

// ==== test/tb_dma_chan_regs.sv ====
// Directed testbench for the DMA channel register block.
// BASE_ADDR stays at zero. Inputs change on the falling clock edge.
// The first failed check stops the run.
`timescale 1ns/1ps

module tb_dma_chan_regs;
  import dma_chan_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 200;

  localparam logic [1:0] HTRANS_IDLE = 2'b00;
  localparam logic [1:0] HTRANS_BUSY = 2'b01;

  // implemented bits of control A and control B.
  localparam logic [31:0] CTRL_A_MASK = 32'hb7ff_ffff;
  localparam logic [31:0] CTRL_B_MASK = 32'h0007_e007;

  logic        hclk;
  logic        hrst_n;
  logic        s_hsel;
  logic [1:0]  s_htrans;
  logic [31:0] s_haddr;
  logic        s_hwrite;
  logic [31:0] s_hwdata;
  logic [31:0] s_hrdata;
  logic        err_vld;
  logic        tfr_vld;
  logic        htfr_vld;
  logic        trgetcmp_vld;
  logic        pend_vld;
  logic        chnen_clr;
  logic [31:0] sarn;
  logic [31:0] darn;
  logic        dgrpaddrc;
  logic        sgrpaddrc;
  logic        grpmc;
  logic [2:0]  chintmdc;
  logic [BLOCK_TL_W-1:0]  block_tl;
  logic [GROUP_LEN_W-1:0] group_len;
  logic [1:0]  sinc;
  logic [1:0]  dinc;
  logic [1:0]  src_tr_width;
  logic [1:0]  dst_tr_width;
  logic [PROTCTL_W-1:0] protctl;
  logic        endlan;
  logic        srcdtlgc;
  logic [1:0]  trgtmdc;
  logic        prot_out;
  logic        int_en;
  logic        chn_en;
  logic        soft_trig;
  logic        int_req;
  logic        pend;

  logic [4:0]  evt_drv; // err, tfr, htfr, trgetcmp, pend from bit 0 up.
  logic [31:0] rng_state;

  assign err_vld      = evt_drv[0];
  assign tfr_vld      = evt_drv[1];
  assign htfr_vld     = evt_drv[2];
  assign trgetcmp_vld = evt_drv[3];
  assign pend_vld     = evt_drv[4];

  dma_chan_regs DUT (.*);

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic drive_addr(input logic sel, input logic [1:0] trans, input logic wr,
                            input logic [31:0] addr);
    s_hsel   = sel;
    s_htrans = trans;
    s_hwrite = wr;
    s_haddr  = addr;
  endtask

  task automatic drive_idle();
    s_hsel   = 1'b0;
    s_htrans = HTRANS_IDLE;
    s_hwrite = 1'b0;
    s_haddr  = '0;
  endtask

  // one address phase, one data phase, then one more cycle so a write has landed.
  task automatic bus_access(input logic sel, input logic [1:0] trans, input logic wr,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge hclk);
    drive_addr(sel, trans, wr, addr);
    @(negedge hclk);
    drive_idle();
    s_hwdata = wdata;
    rdata = s_hrdata; // strobes are high in this cycle.
    @(negedge hclk);
    @(negedge hclk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    bus_access(1'b1, HTRANS_NONSEQ, 1'b1, addr, data, rd);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b1, HTRANS_NONSEQ, 1'b0, addr, 32'h0, data);
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rd;
    bus_read(addr, rd);
    check_word(name, rd, exp);
  endtask

  task automatic pulse_event(input int idx);
    @(negedge hclk);
    evt_drv = 5'(1) << idx;
    @(negedge hclk);
    evt_drv = '0;
  endtask

  `include "tb_dma_chan_tests.svh"

  initial begin
    #((NUM_TESTS * TEST_CYCLES + 10) * CLK_PERIOD);
    $display("Watchdog expired at %0t ns, the run timed out", $time);
    $display("Test failures found");
    $fatal(1, "timeout");
  end

  initial begin
    rng_state = 32'h0823d6c6;
    hrst_n    = 1'b0;
    s_hwdata  = '0;
    evt_drv   = '0;
    chnen_clr = 1'b0;
    drive_idle();
    repeat (4) @(posedge hclk);
    @(negedge hclk);
    hrst_n = 1'b1;

    config_readback();
    write_lock();
    interrupt_flow();
    soft_trigger();
    decode_filter();

    $display("All tests passed!");
    $finish;
  end

endmodule
